// File: verilog/eth_pkg.sv
// line symbol and transmit status types plus link constants for the CSMA/CD model
// imported by every module of the link that needs a symbol, a status or a constant
package eth_pkg;

   // symbols on a station's line and on the merged channel
   typedef enum logic [1:0] {
      sym_jam = 2'd0,   // jam after a collision
      sym_f   = 2'd1,   // frame data
      sym_nd  = 2'd2    // idle line
   } line_sym_t;

   // result of one transmit request, valid for a single cycle
   typedef enum logic [1:0] {
      st_fail    = 2'd0,
      st_success = 2'd1,
      st_na      = 2'd2   // nothing to report
   } tx_status_t;

   // data symbols per frame
   parameter int FRAME_LEN = 4;

   // jam symbols sent once a collision is seen
   parameter int JAM_LEN = 2;

   // collisions after which the request is given up
   parameter int MAX_COLLISIONS = 2;

   // burst and symbol counter width, must hold FRAME_LEN
   parameter int BURST_CNT_W = 3;

endpackage

// File: verilog/symbol_sender.sv
// puts a data or jam burst onto the station's line output
// started by one-cycle pulses from the frame transmitter, answers with burst_done
`timescale 1ns/10ps
module symbol_sender (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               start_data,
   input  logic               start_jam,
   output eth_pkg::line_sym_t line_out,
   output logic               burst_done
);
   import eth_pkg::*;

   // symbols still to go after the one on the line
   logic [BURST_CNT_W-1:0] sym_left;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         line_out   <= sym_nd;
         sym_left   <= '0;
         burst_done <= 1'b0;
      end
      else
      begin
         burst_done <= 1'b0;
         // jam also cuts a running data burst short
         if (start_jam)
         begin
            line_out <= sym_jam;
            sym_left <= BURST_CNT_W'(JAM_LEN - 1);
         end
         else if (start_data)
         begin
            line_out <= sym_f;
            sym_left <= BURST_CNT_W'(FRAME_LEN - 1);
         end
         else if (line_out != sym_nd)
         begin
            // last symbol just went out
            if (sym_left == '0)
            begin
               line_out   <= sym_nd;
               burst_done <= 1'b1;
            end
            else
               sym_left <= sym_left - 1'b1;
         end
      end
   end

   // the transmitter never asks for both burst kinds at once
   a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
      !(start_data && start_jam))
      else $error("start_data and start_jam high together");

   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      burst_done |=> !burst_done)
      else $error("burst_done wider than one cycle");

endmodule

// File: verilog/frame_transmitter.sv
// CSMA/CD transmit control for one station: defer, send, jam, backoff and retry
// holds a request until it reports st_success or st_fail for one cycle
`timescale 1ns/10ps
module frame_transmitter #(
   parameter int BACKOFF_CYCLES = 2
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                tx_req,
   input  logic                carrier_sense,
   input  logic                collision_detect,
   input  logic                burst_done,
   output logic                start_data,
   output logic                start_jam,
   output eth_pkg::tx_status_t tx_status
);
   import eth_pkg::*;

   localparam int COLL_W    = $clog2(MAX_COLLISIONS + 1);
   localparam int BACKOFF_W = $clog2(BACKOFF_CYCLES * MAX_COLLISIONS + 1);

   typedef enum logic [2:0] {
      s_idle,
      s_send,
      s_jam,
      s_backoff,
      s_report,   // status on the output
      s_settle    // requester drops tx_req here
   } tx_state_t;

   tx_state_t             state;
   logic [COLL_W-1:0]     coll_cnt;
   logic [BACKOFF_W-1:0]  backoff_cnt;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= s_idle;
         coll_cnt    <= '0;
         backoff_cnt <= '0;
         start_data  <= 1'b0;
         start_jam   <= 1'b0;
         tx_status   <= st_na;
      end
      else
      begin
         // starts and status are single-cycle pulses
         start_data <= 1'b0;
         start_jam  <= 1'b0;
         tx_status  <= st_na;
         case (state)
            s_idle:
               // defer while someone else holds the line
               if (tx_req && !carrier_sense)
               begin
                  start_data <= 1'b1;
                  state      <= s_send;
               end
            s_send:
               if (collision_detect)
               begin
                  start_jam <= 1'b1;
                  coll_cnt  <= coll_cnt + 1'b1;
                  state     <= s_jam;
               end
               else if (burst_done)
               begin
                  tx_status <= st_success;
                  coll_cnt  <= '0;
                  state     <= s_report;
               end
            s_jam:
               if (burst_done)
               begin
                  if (coll_cnt >= COLL_W'(MAX_COLLISIONS))
                  begin
                     tx_status <= st_fail;
                     coll_cnt  <= '0;
                     state     <= s_report;
                  end
                  else
                  begin
                     // wait grows with the number of collisions so far
                     backoff_cnt <= BACKOFF_W'(BACKOFF_CYCLES * coll_cnt);
                     state       <= s_backoff;
                  end
               end
            s_backoff:
               // retry goes out straight away, the backoff is the arbitration
               if (backoff_cnt == '0)
               begin
                  start_data <= 1'b1;
                  state      <= s_send;
               end
               else
                  backoff_cnt <= backoff_cnt - 1'b1;
            s_report:
               state <= s_settle;
            s_settle:
               state <= s_idle;
            default:
               state <= s_idle;
         endcase
      end
   end

   // the requester sees each result exactly once
   a_status_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      tx_status != st_na |=> tx_status == st_na)
      else $error("tx_status held for more than one cycle");

endmodule

// File: verilog/frame_receiver.sv
// recognises a good frame on the channel and signals it to the upper layer
// rx_frame_ready stays high until an rx_ack pulse
`timescale 1ns/10ps
module frame_receiver (
   input  logic               clk,
   input  logic               rst_n,
   input  eth_pkg::line_sym_t chan_sym,
   input  logic               carrier_sense,
   input  logic               rx_ack,
   output logic               rx_frame_ready
);
   import eth_pkg::*;

   line_sym_t              sym_d1;    // channel symbol, one cycle late
   logic                   rx_en;     // carrier seen with sym_d1
   logic                   rx_en_d;   // one more sample after carrier drops
   line_sym_t              rx_sym;    // receive register
   logic [BURST_CNT_W-1:0] f_cnt;     // consecutive data symbols
   logic                   good_frame;

   // exactly FRAME_LEN data symbols closed by an idle symbol
   assign good_frame = (rx_sym == sym_nd) && (f_cnt == BURST_CNT_W'(FRAME_LEN));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sym_d1         <= sym_nd;
         rx_en          <= 1'b0;
         rx_en_d        <= 1'b0;
         rx_sym         <= sym_nd;
         f_cnt          <= '0;
         rx_frame_ready <= 1'b0;
      end
      else
      begin
         sym_d1  <= chan_sym;
         rx_en   <= carrier_sense;
         rx_en_d <= rx_en;
         // idle symbol when there is nothing to listen to
         if (rx_en || rx_en_d)
            rx_sym <= sym_d1;
         else
            rx_sym <= sym_nd;
         // jam or idle breaks the run, count saturates
         if (rx_sym == sym_f)
         begin
            if (f_cnt != '1)
               f_cnt <= f_cnt + 1'b1;
         end
         else
            f_cnt <= '0;
         // frame while still ready is dropped
         if (rx_ack)
            rx_frame_ready <= 1'b0;
         else if (good_frame)
            rx_frame_ready <= 1'b1;
      end
   end

endmodule

// File: verilog/csma_channel.sv
// shared medium: merges both stations and an external line source
// gives a registered channel symbol, carrier sense and collision detect
`timescale 1ns/10ps
module csma_channel (
   input  logic               clk,
   input  logic               rst_n,
   input  eth_pkg::line_sym_t line_a,
   input  eth_pkg::line_sym_t line_b,
   input  eth_pkg::line_sym_t line_ext,
   output eth_pkg::line_sym_t chan_sym,
   output logic               carrier_sense,
   output logic               collision_detect
);
   import eth_pkg::*;

   logic [1:0] n_active;   // sources not idle
   logic       any_jam;
   line_sym_t  merged;

   assign n_active = {1'b0, line_a != sym_nd} + {1'b0, line_b != sym_nd}
                   + {1'b0, line_ext != sym_nd};
   assign any_jam  = (line_a == sym_jam) || (line_b == sym_jam) || (line_ext == sym_jam);

   // one talker passes through, two or more garble to jam
   always_comb
   begin
      if (n_active == 2'd0)
         merged = sym_nd;
      else if (n_active != 2'd1)
         merged = sym_jam;
      else if (line_a != sym_nd)
         merged = line_a;
      else if (line_b != sym_nd)
         merged = line_b;
      else
         merged = line_ext;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         chan_sym         <= sym_nd;
         carrier_sense    <= 1'b0;
         collision_detect <= 1'b0;
      end
      else
      begin
         chan_sym         <= merged;
         carrier_sense    <= (n_active != 2'd0);
         collision_detect <= (n_active >= 2'd2) || any_jam;
      end
   end

   // both stations rely on seeing carrier whenever a collision is flagged
   a_cd_has_cs: assert property (@(posedge clk) disable iff (!rst_n)
      collision_detect |-> carrier_sense)
      else $error("collision_detect without carrier_sense");

endmodule

// File: verilog/eth_station.sv
// one network node: transmitter, symbol sender and receiver
// BACKOFF_CYCLES sets this node's retry delay per collision
`timescale 1ns/10ps
module eth_station #(
   parameter int BACKOFF_CYCLES = 2
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                tx_req,
   input  logic                rx_ack,
   input  logic                carrier_sense,
   input  logic                collision_detect,
   input  eth_pkg::line_sym_t  chan_sym,
   output eth_pkg::line_sym_t  line_out,
   output eth_pkg::tx_status_t tx_status,
   output logic                rx_frame_ready
);

   // burst control between transmitter and sender
   logic start_data;
   logic start_jam;
   logic burst_done;

   frame_transmitter #(
      .BACKOFF_CYCLES (BACKOFF_CYCLES)
   ) u_tx (
      .clk              (clk),
      .rst_n            (rst_n),
      .tx_req           (tx_req),
      .carrier_sense    (carrier_sense),
      .collision_detect (collision_detect),
      .burst_done       (burst_done),
      .start_data       (start_data),
      .start_jam        (start_jam),
      .tx_status        (tx_status)
   );

   symbol_sender u_sender (
      .clk        (clk),
      .rst_n      (rst_n),
      .start_data (start_data),
      .start_jam  (start_jam),
      .line_out   (line_out),
      .burst_done (burst_done)
   );

   // hears the whole channel, own frames included
   frame_receiver u_rx (
      .clk            (clk),
      .rst_n          (rst_n),
      .chan_sym       (chan_sym),
      .carrier_sense  (carrier_sense),
      .rx_ack         (rx_ack),
      .rx_frame_ready (rx_frame_ready)
   );

endmodule

// File: verilog/eth_link.sv
// top level: two stations on one channel plus an external line source
// ext_line stands in for a third talker on the wire
`timescale 1ns/10ps
module eth_link #(
   parameter int BACKOFF_0 = 2,
   parameter int BACKOFF_1 = 16
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                tx_req_0,
   input  logic                tx_req_1,
   input  logic                rx_ack_0,
   input  logic                rx_ack_1,
   input  eth_pkg::line_sym_t  ext_line,
   output eth_pkg::tx_status_t tx_status_0,
   output eth_pkg::tx_status_t tx_status_1,
   output logic                rx_frame_ready_0,
   output logic                rx_frame_ready_1,
   output logic                carrier_sense,
   output logic                collision_detect
);
   import eth_pkg::*;

   line_sym_t line_0;
   line_sym_t line_1;
   line_sym_t chan_sym;

   // station 0 has the shorter backoff and wins after a collision
   eth_station #(.BACKOFF_CYCLES(BACKOFF_0)) u_station_0 (
      .clk (clk), .rst_n (rst_n),
      .tx_req (tx_req_0), .rx_ack (rx_ack_0),
      .carrier_sense (carrier_sense), .collision_detect (collision_detect),
      .chan_sym (chan_sym), .line_out (line_0),
      .tx_status (tx_status_0), .rx_frame_ready (rx_frame_ready_0)
   );

   eth_station #(.BACKOFF_CYCLES(BACKOFF_1)) u_station_1 (
      .clk (clk), .rst_n (rst_n),
      .tx_req (tx_req_1), .rx_ack (rx_ack_1),
      .carrier_sense (carrier_sense), .collision_detect (collision_detect),
      .chan_sym (chan_sym), .line_out (line_1),
      .tx_status (tx_status_1), .rx_frame_ready (rx_frame_ready_1)
   );

   csma_channel u_channel (
      .clk (clk), .rst_n (rst_n),
      .line_a (line_0), .line_b (line_1), .line_ext (ext_line),
      .chan_sym (chan_sym), .carrier_sense (carrier_sense),
      .collision_detect (collision_detect)
   );

endmodule

// File: verification/eth_checker.sv
// watches the link ports during each stimulus row and compares them with that row's expectations
// also checks the idle outputs right after reset, and keeps the check and error counts
`timescale 1ns/10ps
module eth_checker (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                row_active,
   input  logic [8*24-1:0]     test_name,
   input  eth_pkg::tx_status_t exp_status_0,
   input  eth_pkg::tx_status_t exp_status_1,
   input  int                  exp_frames_0,
   input  int                  exp_frames_1,
   input  int                  exp_first,
   input  logic                exp_coll,
   input  eth_pkg::tx_status_t tx_status_0,
   input  eth_pkg::tx_status_t tx_status_1,
   input  logic                rx_frame_ready_0,
   input  logic                rx_frame_ready_1,
   input  logic                carrier_sense,
   input  logic                collision_detect,
   output int                  check_count,
   output int                  error_count
);
   import eth_pkg::*;

   // what the current row has shown so far
   tx_status_t last_status_0;
   tx_status_t last_status_1;
   int         frames_0;
   int         frames_1;
   int         first_station;   // -1 until a status shows up
   logic       coll_seen;
   logic       ready_q0;
   logic       ready_q1;
   logic       active_q;
   logic       reset_checked;

   function automatic string status_name(input tx_status_t s);
      case (s)
         st_fail:    return "st_fail";
         st_success: return "st_success";
         st_na:      return "st_na";
         default:    return "invalid";
      endcase
   endfunction

   task automatic compare_num(input logic [8*24-1:0] name, input string field,
                              input int exp, input int act);
      check_count++;
      if (exp != act)
      begin
         error_count++;
         $display("[FAIL] %0s: %0s expected %0d, actual %0d", name, field, exp, act);
      end
   endtask

   task automatic compare_status(input logic [8*24-1:0] name, input string field,
                                 input tx_status_t exp, input tx_status_t act);
      check_count++;
      if (exp != act)
      begin
         error_count++;
         $display("[FAIL] %0s: %0s expected %0s, actual %0s", name, field,
                  status_name(exp), status_name(act));
      end
   endtask

   task automatic compare_row();
      compare_status(test_name, "final tx_status_0", exp_status_0, last_status_0);
      compare_status(test_name, "final tx_status_1", exp_status_1, last_status_1);
      compare_num(test_name, "frame events station 0", exp_frames_0, frames_0);
      compare_num(test_name, "frame events station 1", exp_frames_1, frames_1);
      compare_num(test_name, "first station to report", exp_first, first_station);
      compare_num(test_name, "collision_detect seen", int'(exp_coll), int'(coll_seen));
   endtask

   // DUT outputs are flops, so sampling on the rising edge sees settled values
   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         check_count   = 0;
         error_count   = 0;
         reset_checked = 1'b0;
         active_q      = 1'b0;
         ready_q0      = 1'b0;
         ready_q1      = 1'b0;
      end
      else
      begin
         // first edge after reset release, outputs still at reset values
         if (!reset_checked)
         begin
            compare_status("reset_values", "tx_status_0", st_na, tx_status_0);
            compare_status("reset_values", "tx_status_1", st_na, tx_status_1);
            compare_num("reset_values", "rx_frame_ready_0", 0, int'(rx_frame_ready_0));
            compare_num("reset_values", "rx_frame_ready_1", 0, int'(rx_frame_ready_1));
            compare_num("reset_values", "carrier_sense", 0, int'(carrier_sense));
            compare_num("reset_values", "collision_detect", 0, int'(collision_detect));
            reset_checked = 1'b1;
         end
         // new row
         if (row_active && !active_q)
         begin
            last_status_0 = st_na;
            last_status_1 = st_na;
            frames_0      = 0;
            frames_1      = 0;
            first_station = -1;
            coll_seen     = 1'b0;
         end
         if (row_active)
         begin
            if (tx_status_0 != st_na)
            begin
               last_status_0 = tx_status_0;
               if (first_station < 0)
                  first_station = 0;
            end
            if (tx_status_1 != st_na)
            begin
               last_status_1 = tx_status_1;
               if (first_station < 0)
                  first_station = 1;
            end
            // a frame event is a rising rx_frame_ready
            if (rx_frame_ready_0 && !ready_q0)
               frames_0++;
            if (rx_frame_ready_1 && !ready_q1)
               frames_1++;
            if (collision_detect)
               coll_seen = 1'b1;
         end
         // row just closed
         if (!row_active && active_q)
            compare_row();
         ready_q0 = rx_frame_ready_0;
         ready_q1 = rx_frame_ready_1;
         active_q = row_active;
      end
   end

endmodule

// File: verification/tb_eth_link.sv
// testbench for the two-station CSMA/CD link, applies a table of transmit scenarios in a loop
// eth_checker compares the outputs per row, a watchdog bounds the run
`timescale 1ns/10ps
module tb_eth_link;
   import eth_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_ROWS   = 6;
   localparam int EXT_DELAY  = 2;   // cycles into the row before ext_line jams
   localparam int IDLE_END   = 8;   // quiet cycles that close a row

   typedef struct {
      logic [8*24-1:0] name;
      int              off_0;          // request cycle, -1 for none
      int              off_1;
      logic            ext_jam;        // third talker jams during the row
      tx_status_t      status_0;       // final status, st_na when no request
      tx_status_t      status_1;
      int              frames_0;       // rx_frame_ready events
      int              frames_1;
      int              first_station;  // -1 when nobody reports
      logic            coll;           // collision_detect has to rise
   } row_t;

   row_t   rows [NUM_ROWS];
   int     n_rows;
   integer seed;

   logic       clk;
   logic       rst_n;
   logic [1:0] tx_req;
   logic [1:0] rx_ack;
   line_sym_t  ext_line;
   tx_status_t tx_status_0;
   tx_status_t tx_status_1;
   logic       rx_frame_ready_0;
   logic       rx_frame_ready_1;
   logic       carrier_sense;
   logic       collision_detect;

   // row under test, handed to the checker
   logic            row_active;
   logic [8*24-1:0] test_name;
   tx_status_t      exp_status_0;
   tx_status_t      exp_status_1;
   int              exp_frames_0;
   int              exp_frames_1;
   int              exp_first;
   logic            exp_coll;
   int              check_count;
   int              error_count;

   eth_link #(
      .BACKOFF_0 (2),
      .BACKOFF_1 (16)
   ) u_dut (
      .clk              (clk),
      .rst_n            (rst_n),
      .tx_req_0         (tx_req[0]),
      .tx_req_1         (tx_req[1]),
      .rx_ack_0         (rx_ack[0]),
      .rx_ack_1         (rx_ack[1]),
      .ext_line         (ext_line),
      .tx_status_0      (tx_status_0),
      .tx_status_1      (tx_status_1),
      .rx_frame_ready_0 (rx_frame_ready_0),
      .rx_frame_ready_1 (rx_frame_ready_1),
      .carrier_sense    (carrier_sense),
      .collision_detect (collision_detect)
   );

   eth_checker u_check (
      .clk              (clk),
      .rst_n            (rst_n),
      .row_active       (row_active),
      .test_name        (test_name),
      .exp_status_0     (exp_status_0),
      .exp_status_1     (exp_status_1),
      .exp_frames_0     (exp_frames_0),
      .exp_frames_1     (exp_frames_1),
      .exp_first        (exp_first),
      .exp_coll         (exp_coll),
      .tx_status_0      (tx_status_0),
      .tx_status_1      (tx_status_1),
      .rx_frame_ready_0 (rx_frame_ready_0),
      .rx_frame_ready_1 (rx_frame_ready_1),
      .carrier_sense    (carrier_sense),
      .collision_detect (collision_detect),
      .check_count      (check_count),
      .error_count      (error_count)
   );

   task automatic add_row(input logic [8*24-1:0] name, input int off_0, input int off_1,
                          input logic ext_jam, input tx_status_t status_0,
                          input tx_status_t status_1, input int frames_0, input int frames_1,
                          input int first_station, input logic coll);
      rows[n_rows] = '{name, off_0, off_1, ext_jam, status_0, status_1,
                       frames_0, frames_1, first_station, coll};
      n_rows++;
   endtask

   task automatic load_table();
      n_rows = 0;
      //      name                    req0 req1 ext   status 0    status 1  frames first coll
      add_row("idle_after_reset",      -1, -1, 1'b0, st_na,      st_na,      0, 0, -1, 1'b0);
      add_row("lone_station_0",         0, -1, 1'b0, st_success, st_na,      1, 1,  0, 1'b0);
      add_row("lone_station_1",        -1,  0, 1'b0, st_na,      st_success, 1, 1,  1, 1'b0);
      // shorter backoff of station 0 settles the collision
      add_row("same_cycle_collision",   0,  0, 1'b0, st_success, st_success, 2, 2,  0, 1'b1);
      // station 1 asks while the frame of station 0 is on the wire
      add_row("defer_on_carrier",       0,  4, 1'b0, st_success, st_success, 2, 2,  0, 1'b0);
      add_row("ext_jam_give_up",        0, -1, 1'b1, st_fail,    st_na,      0, 0,  0, 1'b1);
   endtask

   task automatic run_row(input int r);
      int         cyc;
      int         idle;
      int         i;
      logic [1:0] done;
      logic [1:0] pend;
      logic [1:0] ready;
      cyc          = 0;
      idle         = 0;
      pend         = 2'b00;
      done         = {rows[r].off_1 < 0, rows[r].off_0 < 0};
      test_name    = rows[r].name;
      exp_status_0 = rows[r].status_0;
      exp_status_1 = rows[r].status_1;
      exp_frames_0 = rows[r].frames_0;
      exp_frames_1 = rows[r].frames_1;
      exp_first    = rows[r].first_station;
      exp_coll     = rows[r].coll;
      row_active   = 1'b1;
      while (done != 2'b11 || idle < IDLE_END)
      begin
         @(negedge clk);
         // a status ends the request
         if (tx_status_0 != st_na)
         begin
            tx_req[0] = 1'b0;
            done[0]   = 1'b1;
         end
         if (tx_status_1 != st_na)
         begin
            tx_req[1] = 1'b0;
            done[1]   = 1'b1;
         end
         if (cyc == rows[r].off_0)
            tx_req[0] = 1'b1;
         if (cyc == rows[r].off_1)
            tx_req[1] = 1'b1;
         // third talker only jams once station 0 is already sending
         if (rows[r].ext_jam && cyc == EXT_DELAY)
            ext_line = sym_jam;
         if (done == 2'b11)
            ext_line = sym_nd;
         // ack one cycle after ready is seen, then release
         ready = {rx_frame_ready_1, rx_frame_ready_0};
         for (i = 0; i < 2; i++)
         begin
            if (rx_ack[i])
               rx_ack[i] = 1'b0;
            else if (pend[i])
            begin
               rx_ack[i] = 1'b1;
               pend[i]   = 1'b0;
            end
            else if (ready[i])
               pend[i] = 1'b1;
         end
         if (carrier_sense)
            idle = 0;
         else
            idle++;
         cyc++;
      end
      row_active = 1'b0;
   endtask

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // every row fits well inside 200 cycles
   initial
   begin
      #(NUM_ROWS * 200 * CLK_PERIOD);
      $display("simulation timed out, rows did not finish within %0d cycles", NUM_ROWS * 200);
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      seed         = 32'h634f_4102;
      rst_n        = 1'b0;
      tx_req       = 2'b00;
      rx_ack       = 2'b00;
      ext_line     = sym_nd;
      row_active   = 1'b0;
      test_name    = '0;
      exp_status_0 = st_na;
      exp_status_1 = st_na;
      exp_frames_0 = 0;
      exp_frames_1 = 0;
      exp_first    = -1;
      exp_coll     = 1'b0;
      load_table();
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      repeat (2) @(negedge clk);
      for (int r = 0; r < n_rows; r++)
      begin
         run_row(r);
         // random quiet gap between rows
         repeat (2 + ($unsigned($random(seed)) % 6)) @(negedge clk);
      end
      repeat (3) @(negedge clk);
      $display("checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: verilog.f
verilog/eth_pkg.sv
verilog/symbol_sender.sv
verilog/frame_transmitter.sv
verilog/frame_receiver.sv
verilog/csma_channel.sv
verilog/eth_station.sv
verilog/eth_link.sv
verification/eth_checker.sv
verification/tb_eth_link.sv

// File: run_sim.sh
#!/bin/sh
# builds the link testbench with Verilator, runs it and searches the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --assert -f verilog.f --top-module tb_eth_link -o sim_eth_link \
   || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_eth_link > sim.log 2>&1 || echo "simulation exited with an error"
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log && { echo "simulation passed"; exit 0; }
echo "no result found in sim.log"
exit 1
